// File: Makefile
TOP = topic_classifier_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/10ps -j 0 --top-module $(TOP) -f topic_classifier.f
	obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: tb/topic_classifier_tb.sv
`timescale 1ns/10ps
`default_nettype none

module topic_classifier_tb import topic_cls_pkg::*; ();

	typedef enum logic [2:0] {OP_NOP, OP_PWR, OP_PRD, OP_UPD, OP_LOOK, OP_RAND} op_t;

	typedef struct packed {
		op_t op;
		pio_addr_t addr;
		pio_data_t data;	// Write data or expected read data.
		key_t key;
		etime_t t;	// Lookup time or new expiry time.
		tid_t tid;
		result_t exp;
	} row_t;

	typedef struct packed {
		logic [31:0] due;
		result_t res;
	} res_exp_t;

	typedef struct packed {
		logic [31:0] due;
		pio_data_t data;
	} pio_exp_t;

	localparam logic [1:0] TBL0 = 2'd0;
	localparam logic [1:0] TBL1 = 2'd1;
	localparam logic [1:0] KEYS = 2'd2;
	localparam pio_data_t JUNK = 64'hFFFF_FFFF_FFFF_FFE0;	// Bits above a bucket.
	localparam key_t KA = 32'h1234_5678;
	localparam key_t KB = 32'hCAFE_0042;
	localparam key_t KC = 32'h1234_5779;	// Same hashes as KA, other key.
	localparam key_t KD = 32'h0BAD_F00D;
	localparam key_t KE = 32'h5555_AAAA;

	logic clk = 1'b0;
	logic reset;
	logic lookup_valid;
	lookup_t lookup;
	logic upd_valid;
	tid_t upd_tid;
	etime_t upd_etime;
	pio_req_t pio;
	logic reg_ack;
	pio_data_t reg_rdata;
	logic res_valid;
	result_t res;
	logic init_done;

	int unsigned cycle = 0;
	int seed = 32'h2b45498e;
	logic table_built = 1'b0;
	row_t rows[$];
	res_exp_t res_q[$];
	pio_exp_t pio_q[$];
	bucket_t shadow_tbl0 [16];
	bucket_t shadow_tbl1 [16];
	key_t shadow_key [16];
	etime_t shadow_etime [16];

	topic_classifier topic_classifier_i (
		.clk(clk), .reset(reset), .lookup_valid(lookup_valid), .lookup(lookup),
		.upd_valid(upd_valid), .upd_tid(upd_tid), .upd_etime(upd_etime),
		.pio(pio), .reg_ack(reg_ack), .reg_rdata(reg_rdata),
		.res_valid(res_valid), .res(res), .init_done(init_done)
	);

	always #4 clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic check_result(result_t got, result_t exp, string what);
		if (got !== exp) begin
			$display(
				"ERR %0t: %s got hit=%0b tid=%0d expired=%0b, expected %0b %0d %0b",
				$time, what, got.hit, got.tid, got.expired, exp.hit, exp.tid, exp.expired);
			abort_run();
		end
	endtask

	task automatic check_pio(pio_data_t got, pio_data_t exp, string what);
		if (got !== exp) begin
			$display("ERR %0t: %s got %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(logic got, logic exp, string what);
		if (got !== exp) begin
			$display("ERR %0t: %s got %0b, expected %0b", $time, what, got, exp);
			abort_run();
		end
	endtask

	// Even nibbles for table 0, odd nibbles for table 1.
	function automatic hidx_t hash0(key_t k);
		return k[3:0] ^ k[11:8] ^ k[19:16] ^ k[27:24];
	endfunction

	function automatic hidx_t hash1(key_t k);
		return k[7:4] ^ k[15:12] ^ k[23:20] ^ k[31:28];
	endfunction

	function automatic result_t model_lookup(key_t key, etime_t now);
		bucket_t b0;
		bucket_t b1;
		result_t r;
		b0 = shadow_tbl0[hash0(key)];
		b1 = shadow_tbl1[hash1(key)];
		r = '0;
		if (b0.valid && shadow_key[b0.tid] == key) begin
			r.hit = 1'b1;	// Table 0 first.
			r.tid = b0.tid;
		end else if (b1.valid && shadow_key[b1.tid] == key) begin
			r.hit = 1'b1;
			r.tid = b1.tid;
		end
		r.expired = r.hit && (shadow_etime[r.tid] < now);
		return r;
	endfunction

	function automatic pio_data_t bucket_data(logic valid, tid_t tid);
		return {59'd0, valid, tid};
	endfunction

	function automatic pio_addr_t qaddr(logic [1:0] region, hidx_t entry);
		return {7'd0, region, entry, 3'd0};	// Byte address of the qword.
	endfunction

	task automatic pio_write_row(logic [1:0] region, hidx_t entry, pio_data_t data);
		row_t row;
		row = '0;
		row.op = OP_PWR;
		row.addr = qaddr(region, entry);
		row.data = data;
		rows.push_back(row);
	endtask

	task automatic key_write_row(tid_t tid, key_t key);
		pio_write_row(KEYS, tid, {32'hA5A5_5A5A, key});	// Upper half is dropped.
	endtask

	task automatic pio_read_row(logic [1:0] region, hidx_t entry, pio_data_t exp);
		row_t row;
		row = '0;
		row.op = OP_PRD;
		row.addr = qaddr(region, entry);
		row.data = exp;
		rows.push_back(row);
	endtask

	task automatic update_row(tid_t tid, etime_t etime);
		row_t row;
		row = '0;
		row.op = OP_UPD;
		row.tid = tid;
		row.t = etime;
		rows.push_back(row);
	endtask

	task automatic lookup_row(key_t key, etime_t now, logic hit, tid_t tid, logic expired);
		row_t row;
		row = '0;
		row.op = OP_LOOK;
		row.key = key;
		row.t = now;
		row.exp.hit = hit;
		row.exp.tid = tid;
		row.exp.expired = expired;
		rows.push_back(row);
	endtask

	task automatic idle_rows(int n);
		row_t row;
		row = '0;
		row.op = OP_NOP;
		for (int i = 0; i < n; i++)
			rows.push_back(row);
	endtask

	task automatic random_rows(int n);
		row_t row;
		row = '0;
		row.op = OP_RAND;
		for (int i = 0; i < n; i++)
			rows.push_back(row);
	endtask

	task automatic build_table();
		for (int rg = 0; rg < 3; rg++)
			for (int e = 0; e < 16; e++)
				pio_read_row(2'(rg), hidx_t'(e), '0);
		key_write_row(4'd3, KA);
		key_write_row(4'd5, KB);
		key_write_row(4'd7, KD);
		key_write_row(4'd9, KE);
		key_write_row(4'd10, KE);
		pio_write_row(TBL0, hash0(KA), JUNK | bucket_data(1'b1, 4'd3));
		pio_write_row(TBL1, hash1(KB), JUNK | bucket_data(1'b1, 4'd5));
		pio_write_row(TBL0, hash0(KD), JUNK | bucket_data(1'b0, 4'd7));	// Invalid bucket.
		pio_write_row(TBL0, hash0(KE), JUNK | bucket_data(1'b1, 4'd9));
		pio_write_row(TBL1, hash1(KE), JUNK | bucket_data(1'b1, 4'd10));
		idle_rows(1);	// Last write lands.
		pio_read_row(TBL0, hash0(KA), bucket_data(1'b1, 4'd3));
		pio_read_row(TBL1, hash1(KB), bucket_data(1'b1, 4'd5));
		pio_read_row(TBL0, hash0(KD), bucket_data(1'b0, 4'd7));
		pio_read_row(TBL1, hash1(KE), bucket_data(1'b1, 4'd10));
		pio_read_row(KEYS, 4'd3, {32'd0, KA});
		pio_read_row(KEYS, 4'd10, {32'd0, KE});
		// Table 0, table 1, key mismatch, invalid bucket, both tables.
		lookup_row(KA, 16'd0, 1'b1, 4'd3, 1'b0);
		lookup_row(KB, 16'd0, 1'b1, 4'd5, 1'b0);
		lookup_row(KC, 16'd0, 1'b0, 4'd0, 1'b0);
		lookup_row(KD, 16'd0, 1'b0, 4'd0, 1'b0);
		lookup_row(KE, 16'd0, 1'b1, 4'd9, 1'b0);
		lookup_row(KA, 16'd100, 1'b1, 4'd3, 1'b1);
		idle_rows(6);	// Drain before the expiry write.
		update_row(4'd3, 16'd200);
		lookup_row(KA, 16'd100, 1'b1, 4'd3, 1'b0);
		lookup_row(KA, 16'd200, 1'b1, 4'd3, 1'b0);
		lookup_row(KA, 16'd201, 1'b1, 4'd3, 1'b1);
		idle_rows(6);
		random_rows(40);
	endtask

	task automatic drive_idle();
		lookup_valid = 1'b0;
		lookup = '0;
		upd_valid = 1'b0;
		upd_tid = '0;
		upd_etime = '0;
		pio = '0;
	endtask

	task automatic apply_row(row_t row);
		key_t key;
		etime_t now;
		logic [31:0] rnd;
		result_t exp;
		res_exp_t rpend;
		pio_exp_t ppend;
		case (row.op)
			OP_PWR: begin
				pio.addr = row.addr;
				pio.din = row.data;
				pio.wr = 1'b1;
				pio.ms = 1'b1;
				case (row.addr[8:7])	// Region from qword bits 5:4.
					TBL0: shadow_tbl0[row.addr[6:3]] = bucket_t'(row.data[4:0]);
					TBL1: shadow_tbl1[row.addr[6:3]] = bucket_t'(row.data[4:0]);
					KEYS: shadow_key[row.addr[6:3]] = row.data[31:0];
					default: ;
				endcase
			end
			OP_PRD: begin
				pio.addr = row.addr;
				pio.rd = 1'b1;
				pio.ms = 1'b1;
				ppend.due = cycle + 1;
				ppend.data = row.data;
				pio_q.push_back(ppend);
			end
			OP_UPD: begin
				upd_valid = 1'b1;
				upd_tid = row.tid;
				upd_etime = row.t;
				shadow_etime[row.tid] = row.t;
			end
			OP_LOOK, OP_RAND: begin
				key = row.key;
				now = row.t;
				if (row.op == OP_RAND) begin
					rnd = $random(seed);
					if (rnd[1:0] != 2'd0)
						key = shadow_key[rnd[7:4]];	// Mostly stored keys.
					else
						key = $random(seed);
					now = etime_t'($random(seed));
				end
				exp = model_lookup(key, now);
				if (row.op == OP_LOOK && exp != row.exp) begin
					$display("A lookup row in the table disagrees with the shadow model.");
					abort_run();
				end
				lookup_valid = 1'b1;
				lookup.key = key;
				lookup.now = now;
				rpend.due = cycle + 5;
				rpend.res = exp;
				res_q.push_back(rpend);
			end
			default: ;
		endcase
	endtask

	// Results and acks must show up exactly on their due cycle.
	always @(negedge clk) begin
		if (!reset) begin
			if (res_valid || (res_q.size() > 0 && res_q[0].due == cycle)) begin
				if (!res_valid || res_q.size() == 0 || res_q[0].due != cycle) begin
					$display("Lookup result missing or at the wrong cycle (cycle %0d).", cycle);
					abort_run();
				end
				check_result(res, res_q[0].res, "lookup result");
				res_q.delete(0);
			end
			if (reg_ack || (pio_q.size() > 0 && pio_q[0].due == cycle)) begin
				if (!reg_ack || pio_q.size() == 0 || pio_q[0].due != cycle) begin
					$display("PIO read ack missing or at the wrong cycle (cycle %0d).", cycle);
					abort_run();
				end
				check_pio(reg_rdata, pio_q[0].data, "PIO read data");
				pio_q.delete(0);
			end
		end
	end

	initial begin : watchdog
		int limit;
		wait (table_built);
		limit = rows.size() * 20 + 50;
		repeat (limit) @(posedge clk);
		$display("Timeout after %0d cycles, the run did not finish.", limit);
		abort_run();
	end

	initial begin
		int unsigned init_due;
		reset = 1'b1;
		drive_idle();
		shadow_tbl0 = '{default: '0};	// Cleared memory.
		shadow_tbl1 = '{default: '0};
		shadow_key = '{default: '0};
		shadow_etime = '{default: '0};
		build_table();
		table_built = 1'b1;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		init_due = cycle + 16;	// One clear write per entry.
		while (cycle != init_due) begin
			check_flag(init_done, 1'b0, "init_done during the clear");
			@(posedge clk);
			#1;
		end
		check_flag(init_done, 1'b1, "init_done after the clear");
		for (int i = 0; i < rows.size(); i++) begin
			drive_idle();
			apply_row(rows[i]);
			@(posedge clk);
			#1;
		end
		drive_idle();
		repeat (8) @(posedge clk);
		if (res_q.size() != 0 || pio_q.size() != 0) begin
			$display("Results still outstanding at the end of the run.");
			abort_run();
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: topic_classifier.f
+incdir+verilog
verilog/topic_cls_pkg.sv
verilog/ram_1r1w.sv
verilog/topic_hash_stage.sv
verilog/topic_cls_mem.sv
verilog/topic_match_stage.sv
verilog/topic_expire_stage.sv
verilog/topic_classifier.sv
tb/topic_classifier_tb.sv

// File: verilog/ram_1r1w.sv
`timescale 1ns/10ps
`default_nettype none

module ram_1r1w #(
	parameter type data_t = logic [7:0],
	parameter int ADDR_NBITS = 4
) (
	input wire clk,
	input wire wr,
	input wire [ADDR_NBITS-1:0] waddr,
	input wire [ADDR_NBITS-1:0] raddr,
	input wire data_t din,
	output data_t dout
);

	localparam int DEPTH = 1 << ADDR_NBITS;

	data_t mem [0:DEPTH-1];

	always_ff @(posedge clk) begin
		if (wr)
			mem[waddr] <= din;
	end

	// Registered read, old data on a same-address write.
	always_ff @(posedge clk) begin
		dout <= mem[raddr];
	end

endmodule

`default_nettype wire

// File: verilog/topic_classifier.sv
`timescale 1ns/10ps
`default_nettype none

module topic_classifier import topic_cls_pkg::*; (
	input wire clk,
	input wire reset,
	input wire lookup_valid,
	input wire lookup_t lookup,
	input wire upd_valid,
	input wire tid_t upd_tid,
	input wire etime_t upd_etime,
	input wire pio_req_t pio,
	output logic reg_ack,
	output pio_data_t reg_rdata,
	output logic res_valid,
	output result_t res,
	output logic init_done
);

	logic req_valid;
	hash_req_t req;
	logic bkt_ack;
	bucket_t bkt0;
	bucket_t bkt1;
	logic key_rd;
	tid_t key_tid0;
	tid_t key_tid1;
	logic key_ack;
	key_t key0;
	key_t key1;
	logic etime_rd;
	tid_t etime_tid;
	logic etime_ack;
	etime_t etime;
	logic hit_valid;
	hit_t hit;

	topic_hash_stage hash_stage (
		.clk(clk), .reset(reset), .lookup_valid(lookup_valid), .lookup(lookup),
		.req_valid(req_valid), .req(req)
	);

	topic_cls_mem mem (
		.clk(clk), .reset(reset), .pio(pio), .reg_ack(reg_ack), .reg_rdata(reg_rdata),
		.tbl_rd(req_valid), .h0(req.h0), .h1(req.h1),
		.bkt_ack(bkt_ack), .bkt0(bkt0), .bkt1(bkt1),
		.key_rd(key_rd), .key_tid0(key_tid0), .key_tid1(key_tid1),
		.key_ack(key_ack), .key0(key0), .key1(key1),
		.etime_rd(etime_rd), .etime_tid(etime_tid), .etime_ack(etime_ack), .etime(etime),
		.upd_valid(upd_valid), .upd_tid(upd_tid), .upd_etime(upd_etime),
		.init_done(init_done)
	);

	topic_match_stage match_stage (
		.clk(clk), .reset(reset), .req_valid(req_valid), .req(req),
		.bkt_ack(bkt_ack), .bkt0(bkt0), .bkt1(bkt1),
		.key_ack(key_ack), .key0(key0), .key1(key1),
		.key_rd(key_rd), .key_tid0(key_tid0), .key_tid1(key_tid1),
		.etime_rd(etime_rd), .etime_tid(etime_tid),
		.hit_valid(hit_valid), .hit(hit)
	);

	topic_expire_stage expire_stage (
		.clk(clk), .reset(reset), .hit_valid(hit_valid), .hit(hit),
		.etime_ack(etime_ack), .etime(etime),
		.res_valid(res_valid), .res(res)
	);

endmodule

`default_nettype wire

// File: verilog/topic_cls_cfg.svh
`ifndef TOPIC_CLS_CFG_SVH
`define TOPIC_CLS_CFG_SVH

// Hash table index width.
`define TCLS_DEPTH_NBITS 4

// Topic id width, also the key and expiry memory index width.
`define TCLS_VALUE_DEPTH_NBITS 4

// Topic key width.
`define TCLS_KEY_NBITS 32

// Expiry and current time width.
`define TCLS_ETIME_NBITS 16

// PIO data and byte address widths.
`define TCLS_PIO_NBITS 64
`define TCLS_PIO_ADDR_NBITS 16

`endif

// File: verilog/topic_cls_mem.sv
`timescale 1ns/10ps
`default_nettype none

module topic_cls_mem import topic_cls_pkg::*; (
	input wire clk,
	input wire reset,
	input wire pio_req_t pio,
	output logic reg_ack,
	output pio_data_t reg_rdata,
	input wire tbl_rd,
	input wire hidx_t h0,
	input wire hidx_t h1,
	output logic bkt_ack,
	output bucket_t bkt0,
	output bucket_t bkt1,
	input wire key_rd,
	input wire tid_t key_tid0,
	input wire tid_t key_tid1,
	output logic key_ack,
	output key_t key0,
	output key_t key1,
	input wire etime_rd,
	input wire tid_t etime_tid,
	output logic etime_ack,
	output etime_t etime,
	input wire upd_valid,
	input wire tid_t upd_tid,
	input wire etime_t upd_etime,
	output logic init_done
);

	localparam int HB = $bits(hidx_t);
	localparam int TB = $bits(tid_t);
	localparam logic [1:0] RGN_TBL0 = 2'd0;
	localparam logic [1:0] RGN_TBL1 = 2'd1;
	localparam logic [1:0] RGN_KEY = 2'd2;

	logic [$bits(pio_addr_t)-4:0] qw;
	logic [1:0] region;
	logic pio_rd;
	logic pio_wr;

	logic pio_wr_q;
	logic [1:0] wr_region_q;
	hidx_t wr_entry_q;
	pio_data_t wr_data_q;
	logic [1:0] rd_region_q;

	logic upd_q;
	tid_t upd_tid_q;
	etime_t upd_etime_q;

	logic [TB:0] clr_cnt;
	logic clr_wr;
	tid_t clr_addr;

	logic tbl0_wr;
	logic tbl1_wr;
	logic key_wr;
	hidx_t tbl_waddr;
	bucket_t tbl_din;
	tid_t key_waddr;
	key_t key_din;
	hidx_t tbl0_raddr;
	hidx_t tbl1_raddr;
	tid_t key0_raddr;

	assign qw = pio.addr[$bits(pio_addr_t)-1:3];	// Qword index.
	assign region = qw[HB+1:HB];
	assign pio_rd = pio.rd & pio.ms;
	assign pio_wr = pio.wr & pio.ms;

	assign clr_wr = ~clr_cnt[TB];
	assign clr_addr = clr_cnt[TB-1:0];
	assign init_done = clr_cnt[TB];

	always_ff @(posedge clk) begin
		if (reset) begin
			clr_cnt <= '0;
			pio_wr_q <= 1'b0;
			upd_q <= 1'b0;
			reg_ack <= 1'b0;
			bkt_ack <= 1'b0;
			key_ack <= 1'b0;
			etime_ack <= 1'b0;
		end else begin
			if (clr_wr)
				clr_cnt <= clr_cnt + 1'b1;	// Stops at all entries done.
			pio_wr_q <= pio_wr;
			upd_q <= upd_valid;
			reg_ack <= pio_rd;
			bkt_ack <= tbl_rd;
			key_ack <= key_rd;
			etime_ack <= etime_rd;
		end
	end

	always_ff @(posedge clk) begin
		wr_region_q <= region;
		wr_entry_q <= hidx_t'(qw[HB-1:0]);
		wr_data_q <= pio.din;
		rd_region_q <= region;	// Region of the read in flight.
		upd_tid_q <= upd_tid;
		upd_etime_q <= upd_etime;
	end

	// The clear wins over PIO and update writes.
	assign tbl0_wr = clr_wr | (pio_wr_q & (wr_region_q == RGN_TBL0));
	assign tbl1_wr = clr_wr | (pio_wr_q & (wr_region_q == RGN_TBL1));
	assign key_wr = clr_wr | (pio_wr_q & (wr_region_q == RGN_KEY));
	assign tbl_waddr = clr_wr ? hidx_t'(clr_addr) : wr_entry_q;
	assign tbl_din = clr_wr ? '0 : bucket_t'(wr_data_q[$bits(bucket_t)-1:0]);
	assign key_waddr = clr_wr ? clr_addr : tid_t'(wr_entry_q);
	assign key_din = clr_wr ? '0 : key_t'(wr_data_q[$bits(key_t)-1:0]);

	// Lookup reads take priority over PIO reads.
	assign tbl0_raddr = tbl_rd ? h0 : hidx_t'(qw[HB-1:0]);
	assign tbl1_raddr = tbl_rd ? h1 : hidx_t'(qw[HB-1:0]);
	assign key0_raddr = key_rd ? key_tid0 : tid_t'(qw[TB-1:0]);

	always_comb begin
		case (rd_region_q)
			RGN_TBL0: reg_rdata = pio_data_t'(bkt0);
			RGN_TBL1: reg_rdata = pio_data_t'(bkt1);
			RGN_KEY: reg_rdata = pio_data_t'(key0);
			default: reg_rdata = '0;
		endcase
	end

	ram_1r1w #(.data_t(bucket_t), .ADDR_NBITS(HB)) tbl0_ram (
		.clk(clk), .wr(tbl0_wr), .waddr(tbl_waddr), .raddr(tbl0_raddr),
		.din(tbl_din), .dout(bkt0)
	);

	ram_1r1w #(.data_t(bucket_t), .ADDR_NBITS(HB)) tbl1_ram (
		.clk(clk), .wr(tbl1_wr), .waddr(tbl_waddr), .raddr(tbl1_raddr),
		.din(tbl_din), .dout(bkt1)
	);

	// Two key copies so both candidates compare together.
	ram_1r1w #(.data_t(key_t), .ADDR_NBITS(TB)) key_ram_a (
		.clk(clk), .wr(key_wr), .waddr(key_waddr), .raddr(key0_raddr),
		.din(key_din), .dout(key0)
	);

	ram_1r1w #(.data_t(key_t), .ADDR_NBITS(TB)) key_ram_b (
		.clk(clk), .wr(key_wr), .waddr(key_waddr), .raddr(key_tid1),
		.din(key_din), .dout(key1)
	);

	ram_1r1w #(.data_t(etime_t), .ADDR_NBITS(TB)) etime_ram (
		.clk(clk), .wr(clr_wr | upd_q), .waddr(clr_wr ? clr_addr : upd_tid_q),
		.raddr(etime_tid), .din(clr_wr ? '0 : upd_etime_q), .dout(etime)
	);

endmodule

`default_nettype wire

// File: verilog/topic_cls_pkg.sv
`default_nettype none

`include "topic_cls_cfg.svh"

package topic_cls_pkg;

	typedef logic [`TCLS_DEPTH_NBITS-1:0] hidx_t;
	typedef logic [`TCLS_VALUE_DEPTH_NBITS-1:0] tid_t;
	typedef logic [`TCLS_KEY_NBITS-1:0] key_t;
	typedef logic [`TCLS_ETIME_NBITS-1:0] etime_t;
	typedef logic [`TCLS_PIO_NBITS-1:0] pio_data_t;
	typedef logic [`TCLS_PIO_ADDR_NBITS-1:0] pio_addr_t;

	typedef struct packed {
		logic valid;	// Bit 4 of the PIO word.
		tid_t tid;
	} bucket_t;

	typedef struct packed {
		key_t key;
		etime_t now;
	} lookup_t;

	// Hash stage to match stage.
	typedef struct packed {
		lookup_t lookup;
		hidx_t h0;
		hidx_t h1;
	} hash_req_t;

	typedef struct packed {
		lookup_t lookup;
		bucket_t bkt0;
		bucket_t bkt1;
	} cand_t;

	// Match stage to expire stage.
	typedef struct packed {
		etime_t now;
		logic hit;
		tid_t tid;
	} hit_t;

	typedef struct packed {
		logic hit;
		tid_t tid;
		logic expired;
	} result_t;

	typedef struct packed {
		pio_addr_t addr;
		pio_data_t din;
		logic rd;
		logic wr;
		logic ms;
	} pio_req_t;

endpackage

`default_nettype wire

// File: verilog/topic_expire_stage.sv
`timescale 1ns/10ps
`default_nettype none

module topic_expire_stage import topic_cls_pkg::*; (
	input wire clk,
	input wire reset,
	input wire hit_valid,
	input wire hit_t hit,
	input wire etime_ack,
	input wire etime_t etime,
	output logic res_valid,
	output result_t res
);

	logic take;
	result_t res_d;

	// Expiry data and hit arrive together.
	assign take = hit_valid & etime_ack;

	always_comb begin
		res_d.hit = hit.hit;
		res_d.tid = hit.hit ? hit.tid : '0;
		res_d.expired = hit.hit && (etime < hit.now);	// Stored time already past.
	end

	always_ff @(posedge clk) begin
		if (reset)
			res_valid <= 1'b0;
		else
			res_valid <= take;
	end

	always_ff @(posedge clk) begin
		if (take)
			res <= res_d;
	end

endmodule

`default_nettype wire

// File: verilog/topic_hash_stage.sv
`timescale 1ns/10ps
`default_nettype none

module topic_hash_stage import topic_cls_pkg::*; (
	input wire clk,
	input wire reset,
	input wire lookup_valid,
	input wire lookup_t lookup,
	output logic req_valid,
	output hash_req_t req
);

	localparam int NIBBLE_PAIRS = $bits(key_t) / 8;

	hidx_t h0;
	hidx_t h1;

	// Even nibbles fold into h0, odd nibbles into h1.
	always_comb begin
		h0 = '0;
		h1 = '0;
		for (int i = 0; i < NIBBLE_PAIRS; i++) begin
			h0 = h0 ^ lookup.key[8*i +: 4];
			h1 = h1 ^ lookup.key[8*i+4 +: 4];
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			req_valid <= 1'b0;
		else
			req_valid <= lookup_valid;	// Drives the table reads.
	end

	always_ff @(posedge clk) begin
		if (lookup_valid) begin
			req.lookup <= lookup;
			req.h0 <= h0;
			req.h1 <= h1;
		end
	end

endmodule

`default_nettype wire

// File: verilog/topic_match_stage.sv
`timescale 1ns/10ps
`default_nettype none

module topic_match_stage import topic_cls_pkg::*; (
	input wire clk,
	input wire reset,
	input wire req_valid,
	input wire hash_req_t req,
	input wire bkt_ack,
	input wire bucket_t bkt0,
	input wire bucket_t bkt1,
	input wire key_ack,
	input wire key_t key0,
	input wire key_t key1,
	output logic key_rd,
	output tid_t key_tid0,
	output tid_t key_tid1,
	output logic etime_rd,
	output tid_t etime_tid,
	output logic hit_valid,
	output hit_t hit
);

	lookup_t look_q;
	cand_t cand;
	logic match0;
	logic match1;
	hit_t hit_d;

	// Lookup waits here while the buckets are read.
	always_ff @(posedge clk) begin
		if (req_valid)
			look_q <= req.lookup;
	end

	// Each candidate tid reads its own key copy.
	assign key_rd = bkt_ack;
	assign key_tid0 = bkt0.tid;
	assign key_tid1 = bkt1.tid;

	always_ff @(posedge clk) begin
		if (bkt_ack) begin
			cand.lookup <= look_q;
			cand.bkt0 <= bkt0;
			cand.bkt1 <= bkt1;
		end
	end

	always_comb begin
		match0 = cand.bkt0.valid && (key0 == cand.lookup.key);
		match1 = cand.bkt1.valid && (key1 == cand.lookup.key);
		hit_d.now = cand.lookup.now;
		hit_d.hit = match0 | match1;
		if (match0)
			hit_d.tid = cand.bkt0.tid;	// Table 0 first.
		else if (match1)
			hit_d.tid = cand.bkt1.tid;
		else
			hit_d.tid = '0;
	end

	// Expiry read goes out with the key compare.
	assign etime_rd = key_ack;
	assign etime_tid = hit_d.tid;

	always_ff @(posedge clk) begin
		if (reset)
			hit_valid <= 1'b0;
		else
			hit_valid <= key_ack;
	end

	always_ff @(posedge clk) begin
		if (key_ack)
			hit <= hit_d;
	end

endmodule

`default_nettype wire
